// File: build.f
rtl/dcache_pkg.sv
rtl/line_fill_if.sv
rtl/load_store_align.sv
rtl/dcache_array.sv
rtl/line_refill_ctrl.sv
rtl/dcache_top.sv
verif/tb_dcache.sv

// File: Makefile
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^TEST PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_dcache.sv
module tb_dcache;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT  = 1000;   // cycles per access, covers the reset sweep
    localparam int N_RANDOM = 2000;

    logic                clk_i;
    logic                reset_i;
    logic                req_i;
    dcache_pkg::mem_op_e op_i;
    logic [31:0]         addr_i;
    logic [31:0]         wdata_i;
    logic                done_o;
    logic [31:0]         rdata_o;
    logic                wb_cyc_o;
    logic                wb_stb_o;
    logic                wb_we_o;
    logic [31:0]         wb_adr_o;
    logic [31:0]         wb_dat_o;
    logic [3:0]          wb_sel_o;
    logic [31:0]         wb_dat_i;
    logic                wb_ack_i;

    logic [31:0] mem [1024];    // 4 KiB behind wishbone
    logic [7:0]  model [4096];  // reference bytes, updated by every store
    int          set_tab [4] = '{3, 17, 42, 63};
    logic [31:0] stim_seed;
    logic [31:0] ack_seed;
    logic [31:0] gap_seed;
    logic        beat_on;
    int          ack_wait;
    int          errors;
    int          checks;
    int          wr_beats;
    int          rd_beats;

    dcache_top u_dut (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .op_i     (op_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .done_o   (done_o),
        .rdata_o  (rdata_o),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_sel_o (wb_sel_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // tags 0..3 and sets below 64 fold into 4 KiB without aliasing
    function automatic int model_ofs(input logic [31:0] a);
        return int'({a[13:12], a[9:0]});
    endfunction

    function automatic int mem_word(input logic [31:0] a);
        return int'({a[13:12], a[9:2]});
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set, input int off);
        return 32'((tag << 12) | (set << 4) | off);
    endfunction

    function automatic int align_off(input dcache_pkg::mem_op_e op, input logic [3:0] raw);
        case (op)
            dcache_pkg::MEM_LH, dcache_pkg::MEM_LHU, dcache_pkg::MEM_SH:
                return int'({raw[3:1], 1'b0});
            dcache_pkg::MEM_LW, dcache_pkg::MEM_SW:
                return int'({raw[3:2], 2'b00});
            default:
                return int'(raw);
        endcase
    endfunction

    function automatic logic writes_memory(input dcache_pkg::mem_op_e op);
        return (op == dcache_pkg::MEM_SB) || (op == dcache_pkg::MEM_SH) ||
               (op == dcache_pkg::MEM_SW);
    endfunction

    // expected load result, little endian with sign or zero extension
    function automatic logic [31:0] model_load(input dcache_pkg::mem_op_e op,
                                               input logic [31:0] a);
        int m;
        m = model_ofs(a);
        case (op)
            dcache_pkg::MEM_LB:  return {{24{model[m][7]}}, model[m]};
            dcache_pkg::MEM_LBU: return {24'd0, model[m]};
            dcache_pkg::MEM_LH:  return {{16{model[m+1][7]}}, model[m+1], model[m]};
            dcache_pkg::MEM_LHU: return {16'd0, model[m+1], model[m]};
            default:             return {model[m+3], model[m+2], model[m+1], model[m]};
        endcase
    endfunction

    task automatic model_store(input dcache_pkg::mem_op_e op, input logic [31:0] a,
                               input logic [31:0] wdata);
        int m;
        m = model_ofs(a);
        model[m] = wdata[7:0];
        if (op != dcache_pkg::MEM_SB) model[m+1] = wdata[15:8];
        if (op == dcache_pkg::MEM_SW) begin
            model[m+2] = wdata[23:16];
            model[m+3] = wdata[31:24];
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic end_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // req holds through the done cycle and idle gaps may precede the next request
    task automatic do_access(input dcache_pkg::mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] got,
                             output int lat);
        int gap;
        gap_seed = lcg_next(gap_seed);
        gap      = int'(gap_seed[17:16]) % 3;  // about half go back to back
        @(negedge clk_i);
        for (int g = 0; g < gap; g++) begin
            req_i = 1'b0;
            @(negedge clk_i);
        end
        req_i   = 1'b1;
        op_i    = op;
        addr_i  = addr;
        wdata_i = wdata;
        lat     = 0;
        got     = '0;
        for (int n = 1; n <= TIMEOUT && lat == 0; n++) begin
            @(negedge clk_i);
            if (done_o) lat = n;
        end
        if (lat == 0) begin
            errors++;
            $display("no done_o within %0d cycles for %s at %h", TIMEOUT, op.name(), addr);
            end_run();
        end else begin
            got = rdata_o;
        end
    endtask

    task automatic run_op(input dcache_pkg::mem_op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata, input string name,
                          output logic [31:0] got, output int lat);
        logic [31:0] exp;
        exp = model_load(op, addr);
        do_access(op, addr, wdata, got, lat);
        if (writes_memory(op)) model_store(op, addr, wdata);
        else check_val(name, exp, got);
    endtask

    // wishbone memory, 0 to 3 wait cycles per beat
    always @(negedge clk_i) begin
        if (reset_i) begin
            wb_ack_i = 1'b0;
            beat_on  = 1'b0;
        end else if (wb_ack_i) begin
            wb_ack_i = 1'b0;                   // stb drops after each ack
        end else if (wb_cyc_o && wb_stb_o) begin
            if (!beat_on) begin
                beat_on  = 1'b1;
                ack_seed = lcg_next(ack_seed);
                ack_wait = int'(ack_seed[17:16]);
            end
            if (ack_wait == 0) begin
                beat_on  = 1'b0;
                wb_ack_i = 1'b1;
                if (wb_we_o) begin
                    // victim data must equal the reference line
                    check_val("wb_write", model_load(dcache_pkg::MEM_LW, wb_adr_o), wb_dat_o);
                    check_val("wb_sel", 32'hf, 32'(wb_sel_o));
                    mem[mem_word(wb_adr_o)] = wb_dat_o;
                    wr_beats++;
                end else begin
                    wb_dat_i = mem[mem_word(wb_adr_o)];
                    rd_beats++;
                end
            end else begin
                ack_wait--;
            end
        end
    end

    always @(posedge clk_i) begin
        if (!reset_i) begin
            if (wb_stb_o && !wb_cyc_o) begin
                errors++;
                $display("wb_stb_o high without wb_cyc_o at %0t", $time);
            end
            if (done_o && !req_i) begin
                errors++;
                $display("done_o pulsed with no pending request at %0t", $time);
            end
        end
    end

    initial begin
        dcache_pkg::mem_op_e load_ops [5];
        dcache_pkg::mem_op_e op;
        logic [31:0]         a;
        logic [31:0]         got;
        int                  lat;
        int                  beats;

        load_ops = '{dcache_pkg::MEM_LB, dcache_pkg::MEM_LH, dcache_pkg::MEM_LW,
                     dcache_pkg::MEM_LBU, dcache_pkg::MEM_LHU};
        clk_i    = 1'b0;
        reset_i  = 1'b1;
        req_i    = 1'b0;
        op_i     = dcache_pkg::MEM_LW;
        addr_i   = '0;
        wdata_i  = '0;
        wb_dat_i = '0;
        wb_ack_i = 1'b0;
        beat_on  = 1'b0;
        ack_wait = 0;
        errors   = 0;
        checks   = 0;
        wr_beats = 0;
        rd_beats = 0;
        stim_seed = 32'h96a350e5;
        ack_seed  = lcg_next(stim_seed ^ 32'h5bd1e995);
        gap_seed  = lcg_next(stim_seed ^ 32'h2545f491);
        for (int w = 0; w < 1024; w++) begin
            mem[w] = (32'(w) * 32'h9e3779b1) ^ (32'(w) << 20);
            for (int b = 0; b < 4; b++) model[4*w+b] = mem[w][8*b +: 8];
        end

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        // every load kind, byte and half picked at the top of the word
        foreach (load_ops[i]) begin
            for (int j = 0; j < 4; j++) begin
                a = make_addr(j % 3, set_tab[j], align_off(load_ops[i], 4'(4*j + 3)));
                run_op(load_ops[i], a, '0, $sformatf("load %s", load_ops[i].name()), got, lat);
            end
        end

        // hit timing, repeated access to a resident line
        a = make_addr(1, set_tab[0], 0);
        run_op(dcache_pkg::MEM_LW, a, '0, "warm", got, lat);
        beats = wr_beats + rd_beats;
        run_op(dcache_pkg::MEM_LW, a + 8, '0, "hit load", got, lat);
        check_val("hit_latency", 32'd1, 32'(lat));
        check_val("hit_no_wb", 32'(beats), 32'(wr_beats + rd_beats));

        // dirty line evicted by a conflicting load
        a = make_addr(0, set_tab[1], 0);
        run_op(dcache_pkg::MEM_SW, a, 32'h5eed0bad, "store", got, lat);
        beats = wr_beats;
        run_op(dcache_pkg::MEM_LW, make_addr(2, set_tab[1], 4), '0, "conflict", got, lat);
        check_val("evict_beats", 32'd4, 32'(wr_beats - beats));
        for (int w = 0; w < 4; w++) begin
            check_val("evict_mem", model_load(dcache_pkg::MEM_LW, a + 4*w),
                      mem[mem_word(a + 4*w)]);
        end

        // byte and half merges
        a = make_addr(1, set_tab[2], 8);
        run_op(dcache_pkg::MEM_SW, a, 32'h11223344, "store", got, lat);
        run_op(dcache_pkg::MEM_SB, a + 1, 32'h000000ab, "store", got, lat);
        run_op(dcache_pkg::MEM_SH, a + 2, 32'h0000cdef, "store", got, lat);
        run_op(dcache_pkg::MEM_LW, a, '0, "merge model", got, lat);
        check_val("merge", 32'hcdefab44, got);
        run_op(dcache_pkg::MEM_LW, a + 4, '0, "merge neighbour", got, lat);

        for (int n = 0; n < N_RANDOM; n++) begin
            stim_seed = lcg_next(stim_seed);
            op = dcache_pkg::mem_op_e'(stim_seed[18:16]);
            a  = make_addr(int'(stim_seed[31:24]) % 3, set_tab[stim_seed[21:20]],
                           align_off(op, stim_seed[15:12]));
            stim_seed = lcg_next(stim_seed);
            run_op(op, a, stim_seed, $sformatf("random %s", op.name()), got, lat);
        end

        // readback of all 12 lines, every set sees conflicts
        for (int t = 0; t < 3; t++) begin
            for (int s = 0; s < 4; s++) begin
                for (int w = 0; w < 4; w++) begin
                    a = make_addr(t, set_tab[s], 4*w);
                    run_op(dcache_pkg::MEM_LW, a, '0, "readback", got, lat);
                end
            end
        end

        @(negedge clk_i);
        req_i = 1'b0;
        end_run();
    end

endmodule

// File: rtl/dcache_top.sv
module dcache_top (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    // core side
    input  logic                                  req_i,
    input  dcache_pkg::mem_op_e                   op_i,
    input  logic [dcache_pkg::ADDR_BITS-1:0]      addr_i,
    input  logic [31:0]                           wdata_i,
    output logic                                  done_o,
    output logic [31:0]                           rdata_o,
    // wishbone master toward memory
    output logic                                  wb_cyc_o,
    output logic                                  wb_stb_o,
    output logic                                  wb_we_o,
    output logic [dcache_pkg::ADDR_BITS-1:0]      wb_adr_o,
    output logic [31:0]                           wb_dat_o,
    output logic [3:0]                            wb_sel_o,
    input  logic [31:0]                           wb_dat_i,
    input  logic                                  wb_ack_i
);

    line_fill_if u_fill ();

    dcache_array u_array (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (req_i),
        .op_i    (op_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .done_o  (done_o),
        .rdata_o (rdata_o),
        .fill    (u_fill.array_mp)
    );

    line_refill_ctrl u_refill (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .fill     (u_fill.ctrl_mp),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_sel_o (wb_sel_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

endmodule

// File: rtl/line_refill_ctrl.sv
module line_refill_ctrl (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    line_fill_if.ctrl_mp                          fill,
    output logic                                  wb_cyc_o,
    output logic                                  wb_stb_o,
    output logic                                  wb_we_o,
    output logic [dcache_pkg::ADDR_BITS-1:0]      wb_adr_o,
    output logic [31:0]                           wb_dat_o,
    output logic [3:0]                            wb_sel_o,
    input  logic [31:0]                           wb_dat_i,
    input  logic                                  wb_ack_i
);

    typedef enum logic [1:0] {
        C_IDLE,
        C_WRITE,
        C_READ
    } ctrl_state_e;

    ctrl_state_e state_q;
    logic [dcache_pkg::BEAT_BITS-1:0]      beat_q;     // word within the line
    logic                                  cyc_q;
    logic                                  stb_q;
    logic                                  done_q;
    dcache_pkg::line_t                     line_buf;
    logic [dcache_pkg::LINE_ADDR_BITS-1:0] beat_line;

    assign beat_line = (state_q == C_WRITE) ? fill.victim_addr : fill.fill_addr;

    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = stb_q;
    assign wb_we_o  = (state_q == C_WRITE);
    assign wb_adr_o = {beat_line, beat_q, 2'b00};
    assign wb_dat_o = fill.victim_line[{beat_q, 5'b00000} +: 32];
    assign wb_sel_o = 4'hf;                    // whole words only

    assign fill.fill_line = line_buf;
    assign fill.fill_done = done_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= C_IDLE;
            beat_q  <= '0;
            cyc_q   <= 1'b0;
            stb_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                C_IDLE: begin
                    // done_q guards against the request still seen in the done cycle
                    if (fill.fill_req && !done_q) begin
                        beat_q  <= '0;
                        state_q <= fill.wb_needed ? C_WRITE : C_READ;
                    end
                end
                default: begin
                    if (!stb_q) begin
                        cyc_q <= 1'b1;         // start next beat
                        stb_q <= 1'b1;
                    end else if (wb_ack_i) begin
                        stb_q  <= 1'b0;
                        beat_q <= beat_q + 1'b1;
                        if (&beat_q) begin
                            cyc_q   <= 1'b0;   // end of this burst phase
                            state_q <= (state_q == C_WRITE) ? C_READ : C_IDLE;
                            done_q  <= (state_q == C_READ);
                        end
                    end
                end
            endcase
        end
    end

    // assemble the incoming line
    always_ff @(posedge clk_i) begin
        if ((state_q == C_READ) && stb_q && wb_ack_i) begin
            line_buf[{beat_q, 5'b00000} +: 32] <= wb_dat_i;
        end
    end

    a_stb_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_stb_o |-> wb_cyc_o);
    a_beat_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o));

endmodule

// File: rtl/dcache_array.sv
module dcache_array (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic                                  req_i,
    input  dcache_pkg::mem_op_e                   op_i,
    input  logic [dcache_pkg::ADDR_BITS-1:0]      addr_i,
    input  logic [31:0]                           wdata_i,
    output logic                                  done_o,
    output logic [31:0]                           rdata_o,
    line_fill_if.array_mp                         fill
);

    localparam int OB = dcache_pkg::OFFSET_BITS;
    localparam int IB = dcache_pkg::INDEX_BITS;
    localparam int TB = dcache_pkg::TAG_BITS;
    localparam int AB = dcache_pkg::ADDR_BITS;

    typedef enum logic [2:0] {
        ST_SWEEP,
        ST_IDLE,
        ST_LOOKUP,
        ST_WAIT_FILL,
        ST_FINISH
    } arr_state_e;

    arr_state_e state_q;
    logic [IB-1:0] sweep_idx_q;

    // storage
    dcache_pkg::line_t data_mem  [dcache_pkg::SETS];
    logic [TB-1:0]     tag_mem   [dcache_pkg::SETS];
    logic              valid_mem [dcache_pkg::SETS];
    logic              dirty_mem [dcache_pkg::SETS];

    // request and set snapshot taken when the request is sampled
    dcache_pkg::mem_op_e op_q;
    logic [AB-1:0]       addr_q;
    logic [31:0]         wdata_q;
    dcache_pkg::line_t   line_q;
    logic [TB-1:0]       tag_q;
    logic                valid_q;
    logic                dirty_q;

    logic [IB-1:0]       idx_in;
    logic [IB-1:0]       idx_q;
    logic                hit;
    logic                install;
    logic                write_access;
    dcache_pkg::line_t   store_line;

    assign idx_in = addr_i[OB +: IB];
    assign idx_q  = addr_q[OB +: IB];
    assign hit    = valid_q && (tag_q == addr_q[AB-1 -: TB]);

    assign install      = (state_q == ST_WAIT_FILL) && fill.fill_done;
    assign write_access = dcache_pkg::is_store(op_q) &&
                          (((state_q == ST_LOOKUP) && hit) || (state_q == ST_FINISH));

    assign done_o = ((state_q == ST_LOOKUP) && hit) || (state_q == ST_FINISH);

    assign fill.fill_req    = ((state_q == ST_LOOKUP) && !hit) || (state_q == ST_WAIT_FILL);
    assign fill.wb_needed   = valid_q && dirty_q;
    assign fill.victim_addr = {tag_q, idx_q};
    assign fill.victim_line = line_q;      // stays put until the fill returns
    assign fill.fill_addr   = addr_q[AB-1:OB];

    load_store_align u_align (
        .line_i   (line_q),
        .offset_i (addr_q[OB-1:0]),
        .op_i     (op_q),
        .wdata_i  (wdata_q),
        .load_o   (rdata_o),
        .line_o   (store_line)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= ST_SWEEP;
            sweep_idx_q <= '0;
        end else begin
            case (state_q)
                ST_SWEEP: begin
                    sweep_idx_q <= sweep_idx_q + 1'b1;
                    if (&sweep_idx_q) state_q <= ST_IDLE; // last set cleared
                end
                ST_IDLE:      if (req_i) state_q <= ST_LOOKUP;
                ST_LOOKUP:    state_q <= hit ? ST_IDLE : ST_WAIT_FILL;
                ST_WAIT_FILL: if (fill.fill_done) state_q <= ST_FINISH;
                default:      state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == ST_IDLE) && req_i) begin
            op_q    <= op_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            line_q  <= data_mem[idx_in];
            tag_q   <= tag_mem[idx_in];
            valid_q <= valid_mem[idx_in];
            dirty_q <= dirty_mem[idx_in];
        end else if (install) begin
            line_q  <= fill.fill_line;         // finish works on the new line
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_SWEEP) valid_mem[sweep_idx_q] <= 1'b0;
        if (install) begin
            data_mem[idx_q]  <= fill.fill_line;
            tag_mem[idx_q]   <= addr_q[AB-1 -: TB];
            valid_mem[idx_q] <= 1'b1;
            dirty_mem[idx_q] <= 1'b0;          // clean until the store lands
        end
        if (write_access) begin
            data_mem[idx_q]  <= store_line;
            dirty_mem[idx_q] <= 1'b1;
        end
    end

    // no new refill request right after a fill completes
    a_fill_release: assert property (@(posedge clk_i) disable iff (reset_i)
        fill.fill_done |=> !fill.fill_req);

endmodule

// File: rtl/load_store_align.sv
module load_store_align (
    input  dcache_pkg::line_t                     line_i,
    input  logic [dcache_pkg::OFFSET_BITS-1:0]    offset_i,
    input  dcache_pkg::mem_op_e                   op_i,
    input  logic [31:0]                           wdata_i,
    output logic [31:0]                           load_o,
    output dcache_pkg::line_t                     line_o
);

    localparam int OB = dcache_pkg::OFFSET_BITS;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] word_sel;
    logic        misaligned;

    assign byte_sel = line_i[{offset_i, 3'b000} +: 8];
    assign half_sel = line_i[{offset_i[OB-1:1], 4'b0000} +: 16];
    assign word_sel = line_i[{offset_i[OB-1:2], 5'b00000} +: 32];

    // load extraction with sign or zero extension
    always_comb begin
        case (op_i)
            dcache_pkg::MEM_LB:  load_o = {{24{byte_sel[7]}}, byte_sel};
            dcache_pkg::MEM_LH:  load_o = {{16{half_sel[15]}}, half_sel};
            dcache_pkg::MEM_LBU: load_o = {24'd0, byte_sel};
            dcache_pkg::MEM_LHU: load_o = {16'd0, half_sel};
            default:             load_o = word_sel; // lw, stores read back the word
        endcase
    end

    // store merge, loads pass the line through
    always_comb begin
        line_o = line_i;
        case (op_i)
            dcache_pkg::MEM_SB: line_o[{offset_i, 3'b000} +: 8] = wdata_i[7:0];
            dcache_pkg::MEM_SH: line_o[{offset_i[OB-1:1], 4'b0000} +: 16] = wdata_i[15:0];
            dcache_pkg::MEM_SW: line_o[{offset_i[OB-1:2], 5'b00000} +: 32] = wdata_i;
            default: ;
        endcase
    end

    always_comb begin
        case (op_i)
            dcache_pkg::MEM_LH, dcache_pkg::MEM_LHU, dcache_pkg::MEM_SH:
                misaligned = offset_i[0];
            dcache_pkg::MEM_LW, dcache_pkg::MEM_SW:
                misaligned = |offset_i[1:0];
            default:
                misaligned = 1'b0;
        endcase
    end

    always_comb begin
        a_aligned: assert final (!misaligned)
            else $error("misaligned %s at offset %0d", op_i.name(), offset_i);
    end

endmodule

// File: rtl/line_fill_if.sv
interface line_fill_if;

    logic                                     fill_req;    // held until fill_done
    logic                                     wb_needed;   // victim is valid and dirty
    logic [dcache_pkg::LINE_ADDR_BITS-1:0]    victim_addr;
    dcache_pkg::line_t                        victim_line;
    logic [dcache_pkg::LINE_ADDR_BITS-1:0]    fill_addr;
    dcache_pkg::line_t                        fill_line;
    logic                                     fill_done;   // one cycle pulse

    modport array_mp (
        output fill_req,
        output wb_needed,
        output victim_addr,
        output victim_line,
        output fill_addr,
        input  fill_line,
        input  fill_done
    );

    modport ctrl_mp (
        input  fill_req,
        input  wb_needed,
        input  victim_addr,
        input  victim_line,
        input  fill_addr,
        output fill_line,
        output fill_done
    );

endinterface

// File: rtl/dcache_pkg.sv
package dcache_pkg;

    // address split is tag | index | offset
    localparam int ADDR_BITS      = 32;
    localparam int LINE_BYTES     = 16;
    localparam int LINE_WORDS     = LINE_BYTES / 4;      // one wishbone beat per word
    localparam int LINE_BITS      = LINE_BYTES * 8;
    localparam int OFFSET_BITS    = $clog2(LINE_BYTES);
    localparam int INDEX_BITS     = 8;
    localparam int SETS           = 1 << INDEX_BITS;
    localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int LINE_ADDR_BITS = TAG_BITS + INDEX_BITS; // line number in memory
    localparam int BEAT_BITS      = $clog2(LINE_WORDS);

    typedef logic [LINE_BITS-1:0] line_t;

    // access kinds seen on the core port
    typedef enum logic [2:0] {
        MEM_LB  = 3'd0,
        MEM_LH  = 3'd1,
        MEM_LW  = 3'd2,
        MEM_LBU = 3'd3,
        MEM_LHU = 3'd4,
        MEM_SB  = 3'd5,
        MEM_SH  = 3'd6,
        MEM_SW  = 3'd7
    } mem_op_e;

    function automatic logic is_store(mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

endpackage
